/* include/fpu_consts.svh */
/*
 * fpu constants
 * binary32 field widths, exponent bias, working significand width,
 * canonical quiet NaN and the bit positions of the exception flags
 */
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// binary32 fields
`define FPU_EXP_W  8
`define FPU_MAN_W  23
`define FPU_BIAS   127

// carry, hidden, 23 fraction bits, guard, round, sticky
`define FPU_WORK_W 28

`define FPU_QNAN   32'h7FC00000

// flag bits, invalid down to inexact
`define FPU_FLAG_NV 4
`define FPU_FLAG_DZ 3
`define FPU_FLAG_OF 2
`define FPU_FLAG_UF 1
`define FPU_FLAG_NX 0

`endif

/* design/fpu_pkg.sv */
/*
 * fpu_pkg
 * opcode, rounding mode and outcome class types shared by the
 * three pipeline stages of the single precision FPU
 */
`default_nettype none

package fpu_pkg;

   // funct7 encodings, anything else is a no-op
   typedef enum logic [6:0] {
      OP_ADD = 7'b0100000,
      OP_SUB = 7'b0100100,
      OP_MUL = 7'b0000010
   } fpu_op_e;

   // frm encodings, 101 to 111 behave as RNE
   typedef enum logic [2:0] {
      RM_RNE = 3'b000,
      RM_RTZ = 3'b001,
      RM_RDN = 3'b010,
      RM_RUP = 3'b011,
      RM_RMM = 3'b100
   } round_mode_e;

   // outcome class of one operation
   // decided in decode, refined on cancellation in execute
   typedef enum logic [1:0] {
      CL_NORM = 2'd0,
      CL_ZERO = 2'd1,
      CL_INF  = 2'd2,
      CL_NAN  = 2'd3
   } fp_class_e;

endpackage

`default_nettype wire

/* design/fpu_stage_if.sv */
/*
 * fpu_stage_if
 * one operation in flight between two FPU pipeline stages
 */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_consts.svh"

interface fpu_stage_if ();
   import fpu_pkg::*;

   fpu_op_e                op;
   round_mode_e            rm;
   fp_class_e              cls;
   // result sign, or sign of the larger operand for add and sub
   logic                   sign;
   // effective magnitude subtraction
   logic                   sub;
   // biased exponent, extra bits hold overflow and underflow
   logic signed [9:0]      exp;
   // larger significand or product bits
   logic [`FPU_WORK_W-1:0] man_a;
   // aligned smaller significand with sticky
   logic [`FPU_WORK_W-1:0] man_b;
   logic                   nv;

   modport source (output op, rm, cls, sign, sub, exp, man_a, man_b, nv);
   modport sink   (input  op, rm, cls, sign, sub, exp, man_a, man_b, nv);

endinterface

`default_nettype wire

/* design/fpu_decode.sv */
/*
 * fpu_decode
 * stage 1: unpack and classify operands, order and align for add/sub,
 * multiply significands for mul, register into the stage-1 interface
 */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_consts.svh"

module fpu_decode (
   input  logic                 clk,
   input  logic                 nrst,
   input  logic [31:0]          a,
   input  logic [31:0]          b,
   input  fpu_pkg::fpu_op_e     funct7,
   input  fpu_pkg::round_mode_e frm,
   fpu_stage_if.source          s1
);
   import fpu_pkg::*;

   localparam logic signed [9:0] BIAS = `FPU_BIAS;

   // unpacked fields, subnormals read as zero
   logic                  sa;
   logic                  sb;
   logic                  sb_eff;
   logic [`FPU_EXP_W-1:0] ea;
   logic [`FPU_EXP_W-1:0] eb;
   logic [`FPU_MAN_W:0]   ma;
   logic [`FPU_MAN_W:0]   mb;
   logic                  a_zero;
   logic                  b_zero;
   logic                  a_inf;
   logic                  b_inf;
   logic                  a_nan;
   logic                  b_nan;

   // magnitude ordering and alignment
   logic                  a_big;
   logic                  sign_l;
   logic [`FPU_EXP_W-1:0] exp_l;
   logic [`FPU_EXP_W-1:0] exp_s;
   logic [`FPU_EXP_W-1:0] diff;
   logic [4:0]            dsh;
   logic [`FPU_MAN_W:0]   man_l;
   logic [`FPU_MAN_W:0]   man_s;
   logic [50:0]           shifted;
   logic [47:0]           prod;

   // next register values
   fp_class_e              n_cls;
   logic                   n_sign;
   logic                   n_sub;
   logic                   n_nv;
   logic signed [9:0]      n_exp;
   logic [`FPU_WORK_W-1:0] n_man_a;
   logic [`FPU_WORK_W-1:0] n_man_b;

   assign sa     = a[31];
   assign sb     = b[31];
   assign ea     = a[`FPU_MAN_W +: `FPU_EXP_W];
   assign eb     = b[`FPU_MAN_W +: `FPU_EXP_W];
   assign a_zero = (ea == '0);
   assign b_zero = (eb == '0);
   assign a_inf  = (ea == '1) && (a[`FPU_MAN_W-1:0] == '0);
   assign b_inf  = (eb == '1) && (b[`FPU_MAN_W-1:0] == '0);
   assign a_nan  = (ea == '1) && (a[`FPU_MAN_W-1:0] != '0);
   assign b_nan  = (eb == '1) && (b[`FPU_MAN_W-1:0] != '0);
   assign ma     = a_zero ? '0 : {1'b1, a[`FPU_MAN_W-1:0]};
   assign mb     = b_zero ? '0 : {1'b1, b[`FPU_MAN_W-1:0]};

   // subtraction is addition with b negated
   assign sb_eff = sb ^ (funct7 == OP_SUB);
   assign a_big  = {ea, ma} >= {eb, mb};
   assign sign_l = a_big ? sa : sb_eff;
   assign exp_l  = a_big ? ea : eb;
   assign exp_s  = a_big ? eb : ea;
   assign man_l  = a_big ? ma : mb;
   assign man_s  = a_big ? mb : ma;
   assign diff   = exp_l - exp_s;

   // past 26 places the whole smaller significand is sticky
   assign dsh     = (diff > 8'd26) ? 5'd26 : diff[4:0];
   assign shifted = {man_s, 27'd0} >> dsh;
   assign prod    = ma * mb;

   always_comb begin
      n_cls   = CL_ZERO;
      n_sign  = 1'b0;
      n_sub   = 1'b0;
      n_nv    = 1'b0;
      n_exp   = '0;
      n_man_a = '0;
      n_man_b = '0;
      case (funct7)
         OP_ADD, OP_SUB: begin
            n_sign  = sign_l;
            n_sub   = sa ^ sb_eff;
            n_exp   = $signed({2'b00, exp_l});
            n_man_a = {1'b0, man_l, 3'b000};
            // hidden..round from the shift, the rest folded into sticky
            n_man_b = {1'b0, shifted[50:25], (shifted[24:0] != '0)};
            if (a_nan || b_nan) begin
               n_cls = CL_NAN;
            end else if (a_inf && b_inf && (sa != sb_eff)) begin
               n_cls = CL_NAN;
               n_nv  = 1'b1;
            end else if (a_inf || b_inf) begin
               n_cls  = CL_INF;
               n_sign = a_inf ? sa : sb_eff;
            end else if (a_zero && b_zero) begin
               // opposite-signed zeros give +0, or -0 when rounding down
               n_cls  = CL_ZERO;
               n_sign = (sa == sb_eff) ? sa : (frm == RM_RDN);
            end else begin
               n_cls = CL_NORM;
            end
         end
         OP_MUL: begin
            n_sign  = sa ^ sb;
            n_exp   = $signed({2'b00, ea}) + $signed({2'b00, eb}) - BIAS;
            // carry, hidden, fraction, guard, round, then sticky
            n_man_a = {prod[47:21], (prod[20:0] != '0)};
            if (a_nan || b_nan) begin
               n_cls = CL_NAN;
            end else if ((a_zero && b_inf) || (a_inf && b_zero)) begin
               n_cls = CL_NAN;
               n_nv  = 1'b1;
            end else if (a_inf || b_inf) begin
               n_cls = CL_INF;
            end else if (a_zero || b_zero) begin
               n_cls = CL_ZERO;
            end else begin
               n_cls = CL_NORM;
            end
         end
         default: ;
      endcase
   end

   // control fields, no-op after reset
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         s1.op  <= fpu_op_e'(7'd0);
         s1.rm  <= RM_RNE;
         s1.cls <= CL_ZERO;
         s1.nv  <= 1'b0;
         s1.sub <= 1'b0;
      end else begin
         s1.op  <= funct7;
         s1.rm  <= frm;
         s1.cls <= n_cls;
         s1.nv  <= n_nv;
         s1.sub <= n_sub;
      end
   end

   always_ff @(posedge clk) begin
      s1.sign  <= n_sign;
      s1.exp   <= n_exp;
      s1.man_a <= n_man_a;
      s1.man_b <= n_man_b;
   end

   // execute relies on a non-negative magnitude difference
   a_align_order: assert property (@(posedge clk) disable iff (!nrst)
      s1.sub |-> (s1.man_b <= s1.man_a));

endmodule

`default_nettype wire

/* design/fpu_execute.sv */
/*
 * fpu_execute
 * stage 2: add or subtract the aligned significands, or take the
 * product, normalize to the hidden bit and register into stage-2
 */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_consts.svh"

module fpu_execute (
   input  logic      clk,
   input  logic      nrst,
   fpu_stage_if.sink   s1,
   fpu_stage_if.source s2
);
   import fpu_pkg::*;

   logic [`FPU_WORK_W-1:0] sum;
   logic [`FPU_WORK_W-1:0] norm;
   logic [4:0]             lz;
   logic signed [9:0]      n_exp;
   fp_class_e              n_cls;
   logic                   n_sign;

   // leading zeros below the carry bit, 27 for an all-zero input
   function automatic logic [4:0] lzc27(input logic [26:0] v);
      logic [4:0] n;
      logic       found;
      n     = 5'd0;
      found = 1'b0;
      for (int i = 26; i >= 0; i--) begin
         if (!found) begin
            if (v[i]) begin
               found = 1'b1;
            end else begin
               n = n + 5'd1;
            end
         end
      end
      return n;
   endfunction

   // man_b never exceeds man_a on subtraction, so no borrow out
   assign sum = s1.sub ? (s1.man_a - s1.man_b) : (s1.man_a + s1.man_b);
   assign lz  = lzc27(sum[26:0]);

   always_comb begin
      norm   = s1.man_a;
      n_exp  = s1.exp;
      n_cls  = s1.cls;
      n_sign = s1.sign;
      case (s1.op)
         OP_ADD, OP_SUB: begin
            if (sum[27]) begin
               // carry out, shift right keeping the dropped bit sticky
               norm  = {1'b0, sum[27:2], sum[1] | sum[0]};
               n_exp = s1.exp + 10'sd1;
            end else begin
               norm  = sum << lz;
               n_exp = s1.exp - $signed({5'b00000, lz});
            end
            // exact cancellation
            if ((s1.cls == CL_NORM) && (sum == '0)) begin
               n_cls  = CL_ZERO;
               n_sign = (s1.rm == RM_RDN);
            end
         end
         OP_MUL: begin
            // product in [1,4), at most one bit to the right
            if (s1.man_a[27]) begin
               norm  = {1'b0, s1.man_a[27:2], s1.man_a[1] | s1.man_a[0]};
               n_exp = s1.exp + 10'sd1;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         s2.op  <= fpu_op_e'(7'd0);
         s2.rm  <= RM_RNE;
         s2.cls <= CL_ZERO;
         s2.nv  <= 1'b0;
         s2.sub <= 1'b0;
      end else begin
         s2.op  <= s1.op;
         s2.rm  <= s1.rm;
         s2.cls <= n_cls;
         s2.nv  <= s1.nv;
         s2.sub <= s1.sub;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      s2.sign  <= n_sign;
      s2.exp   <= n_exp;
      s2.man_a <= norm;
      s2.man_b <= s1.man_b;
   end

   // rounding in the result stage expects 01.xxx
   a_norm_hidden: assert property (@(posedge clk) disable iff (!nrst)
      (s2.cls == CL_NORM) |-> (s2.man_a[27:26] == 2'b01));

endmodule

`default_nettype wire

/* design/fpu_result.sv */
/*
 * fpu_result
 * stage 3: round by mode, handle overflow and underflow, encode the
 * special classes and assemble the five exception flags
 */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_consts.svh"

module fpu_result (
   fpu_stage_if.sink   s2,
   output logic [31:0] result,
   output logic [4:0]  flags
);
   import fpu_pkg::*;

   logic                  lsb;
   logic                  g;
   logic                  r;
   logic                  s;
   logic                  lost;
   logic                  inc;
   logic                  carry;
   logic [24:0]           rounded;
   logic [`FPU_MAN_W-1:0] frac;
   logic signed [9:0]     exp_r;
   logic                  to_max;
   logic                  op_ok;

   always_comb begin
      lsb  = s2.man_a[3];
      g    = s2.man_a[2];
      r    = s2.man_a[1];
      s    = s2.man_a[0];
      lost = g | r | s;

      // increment decision per mode
      case (s2.rm)
         RM_RTZ:  inc = 1'b0;
         RM_RDN:  inc = s2.sign & lost;
         RM_RUP:  inc = ~s2.sign & lost;
         RM_RMM:  inc = g;
         default: inc = g & (r | s | lsb);
      endcase

      rounded = {1'b0, s2.man_a[26:3]} + {24'd0, inc};
      // a rounding carry leaves 1.000..0 and bumps the exponent
      carry   = rounded[24];
      frac    = carry ? rounded[23:1] : rounded[22:0];
      exp_r   = carry ? (s2.exp + 10'sd1) : s2.exp;

      // modes whose overflow saturates at the largest finite value
      case (s2.rm)
         RM_RTZ:  to_max = 1'b1;
         RM_RDN:  to_max = ~s2.sign;
         RM_RUP:  to_max = s2.sign;
         default: to_max = 1'b0;
      endcase
   end

   assign op_ok = (s2.op == OP_ADD) || (s2.op == OP_SUB) || (s2.op == OP_MUL);

   always_comb begin
      result = '0;
      flags  = '0;
      if (op_ok) begin
         case (s2.cls)
            CL_NAN: begin
               result              = `FPU_QNAN;
               flags[`FPU_FLAG_NV] = s2.nv;
            end
            CL_INF: begin
               result = {s2.sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
            end
            CL_ZERO: begin
               result = {s2.sign, 31'd0};
            end
            default: begin
               if (s2.exp < 10'sd1) begin
                  // below the smallest normal flushes to signed zero
                  result              = {s2.sign, 31'd0};
                  flags[`FPU_FLAG_UF] = 1'b1;
                  flags[`FPU_FLAG_NX] = 1'b1;
               end else if (exp_r >= 10'sd255) begin
                  if (to_max) begin
                     result = {s2.sign, 8'hFE, {`FPU_MAN_W{1'b1}}};
                  end else begin
                     result = {s2.sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
                  end
                  flags[`FPU_FLAG_OF] = 1'b1;
                  flags[`FPU_FLAG_NX] = 1'b1;
               end else begin
                  result              = {s2.sign, exp_r[7:0], frac};
                  flags[`FPU_FLAG_NX] = lost;
               end
            end
         endcase
      end
      // divide-by-zero never set without division
      flags[`FPU_FLAG_DZ] = 1'b0;
   end

   // invalid only ever arrives with the NaN class from upstream
   always_comb begin
      if (op_ok && s2.nv) begin
         a_nv_is_nan: assert final (s2.cls == CL_NAN);
      end
   end

endmodule

`default_nettype wire

/* design/fpu_top.sv */
/*
 * fpu_top
 * three-stage binary32 add/sub/mul unit, result and flags
 * two clock edges after the operands are sampled
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_top (
   input  logic        clk,
   input  logic        nrst,
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [6:0]  funct7,
   input  logic [2:0]  frm,
   output logic [31:0] result,
   output logic [4:0]  flags
);
   import fpu_pkg::*;

   // decode -> execute, execute -> result
   fpu_stage_if s1_if ();
   fpu_stage_if s2_if ();

   fpu_decode decode_i (
      .clk    (clk),
      .nrst   (nrst),
      .a      (a),
      .b      (b),
      .funct7 (fpu_op_e'(funct7)),
      .frm    (round_mode_e'(frm)),
      .s1     (s1_if.source)
   );

   fpu_execute execute_i (
      .clk  (clk),
      .nrst (nrst),
      .s1   (s1_if.sink),
      .s2   (s2_if.source)
   );

   fpu_result result_i (
      .s2     (s2_if.sink),
      .result (result),
      .flags  (flags)
   );

endmodule

`default_nettype wire

/* dv/fpu_tb.sv */
/*
 * fpu testbench
 * random and directed add/sub/mul traffic against a bit-exact model,
 * results checked two clock edges after the operands are driven
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_tb;

   // funct7 encodings, F_NOP is any code outside the three
   localparam logic [6:0] F_ADD = 7'b0100000;
   localparam logic [6:0] F_SUB = 7'b0100100;
   localparam logic [6:0] F_MUL = 7'b0000010;
   localparam logic [6:0] F_NOP = 7'h7F;

   logic        clk;
   logic        nrst;
   logic [31:0] a;
   logic [31:0] b;
   logic [6:0]  funct7;
   logic [2:0]  frm;
   logic [31:0] result;
   logic [4:0]  flags;

   integer seed;
   int     cyc;
   int     checks;
   int     errors;
   int     test_err0;
   int     tests_run;
   int     tests_failed;
   logic   timed_out;

   // in-flight operations, expected value packed as {flags, result}
   int          q_due[$];
   logic [31:0] q_a[$];
   logic [31:0] q_b[$];
   logic [9:0]  q_op[$];
   logic [36:0] q_exp[$];

   // zeros, infinities, NaNs, subnormals and two plain normals
   logic [31:0] specials [10] = '{32'h00000000, 32'h80000000, 32'h7F800000,
      32'hFF800000, 32'h7FC00000, 32'h7F800001, 32'h00000123, 32'h80400000,
      32'h3F800000, 32'hC0400000};
   logic [6:0] valid_ops [3] = '{F_ADD, F_SUB, F_MUL};

   fpu_top dut_i (
      .clk    (clk),
      .nrst   (nrst),
      .a      (a),
      .b      (b),
      .funct7 (funct7),
      .frm    (frm),
      .result (result),
      .flags  (flags)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // reset low for two cycles, released on a falling edge
   initial begin
      nrst = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      nrst = 1'b1;
   end

   function automatic logic [31:0] rnd(input int unsigned n);
      return 32'({$random(seed)} % n);
   endfunction

   // random sign and fraction around a given biased exponent
   function automatic logic [31:0] rand_fp(input int e);
      logic [31:0] r;
      r = $random(seed);
      return {r[31], e[7:0], r[22:0]};
   endfunction

   // exact magnitude m * 2^e rounded to binary32, {flags, result}
   function automatic logic [36:0] round_to_single(input logic s, input logic [299:0] m,
                                                   input int e, input logic [2:0] rm);
      int           p;
      int           be;
      logic [299:0] keep;
      logic         g;
      logic         rest;
      logic         lost;
      logic         inc;
      logic         to_max;
      p = 0;
      for (int i = 0; i < 300; i++) begin
         if (m[i]) begin
            p = i;
         end
      end
      be = p + e + 127;
      // below the smallest normal before rounding
      if (be < 1) begin
         return {5'b00011, s, 31'd0};
      end
      if (p >= 24) begin
         keep = m >> (p - 23);
         g    = m[p - 24];
         rest = (m << (324 - p)) != '0;
      end else begin
         keep = m << (23 - p);
         g    = 1'b0;
         rest = 1'b0;
      end
      lost = g | rest;
      case (rm)
         3'b001:  inc = 1'b0;
         3'b010:  inc = s & lost;
         3'b011:  inc = ~s & lost;
         3'b100:  inc = g;
         default: inc = g & (rest | keep[0]);
      endcase
      keep = keep + 300'(inc);
      if (keep[24]) begin
         keep = keep >> 1;
         be   = be + 1;
      end
      if (be >= 255) begin
         to_max = (rm == 3'b001) || ((rm == 3'b010) && !s) || ((rm == 3'b011) && s);
         if (to_max) begin
            return {5'b00101, s, 8'hFE, 23'h7FFFFF};
         end
         return {5'b00101, s, 8'hFF, 23'd0};
      end
      return {4'b0000, lost, s, be[7:0], keep[22:0]};
   endfunction

   // reference model of one operation
   function automatic logic [36:0] fp_model(input logic [31:0] x, input logic [31:0] y,
                                            input logic [6:0] f7, input logic [2:0] rm);
      logic         sx;
      logic         sy;
      logic         s;
      int           ex;
      int           ey;
      int           emin;
      logic         xz;
      logic         yz;
      logic         xi;
      logic         yi;
      logic [299:0] mx;
      logic [299:0] my;
      logic [299:0] mag;
      sx = x[31];
      sy = y[31];
      ex = int'(x[30:23]);
      ey = int'(y[30:23]);
      // subnormals count as zero
      xz = (ex == 0);
      yz = (ey == 0);
      xi = (ex == 255) && (x[22:0] == '0);
      yi = (ey == 255) && (y[22:0] == '0);
      mx = xz ? '0 : 300'({1'b1, x[22:0]});
      my = yz ? '0 : 300'({1'b1, y[22:0]});
      if ((f7 != F_ADD) && (f7 != F_SUB) && (f7 != F_MUL)) begin
         return '0;
      end
      // NaN input, quiet result without invalid
      if (((ex == 255) && !xi) || ((ey == 255) && !yi)) begin
         return {5'd0, 32'h7FC00000};
      end
      if (f7 == F_MUL) begin
         if ((xz && yi) || (xi && yz)) begin
            return {5'b10000, 32'h7FC00000};
         end
         if (xi || yi) begin
            return {5'd0, sx ^ sy, 8'hFF, 23'd0};
         end
         if (xz || yz) begin
            return {5'd0, sx ^ sy, 31'd0};
         end
         return round_to_single(sx ^ sy, mx * my, ex + ey - 300, rm);
      end
      if (f7 == F_SUB) begin
         sy = ~sy;
      end
      if (xi && yi && (sx != sy)) begin
         return {5'b10000, 32'h7FC00000};
      end
      if (xi || yi) begin
         return {5'd0, xi ? sx : sy, 8'hFF, 23'd0};
      end
      if (xz && yz) begin
         return {5'd0, (sx == sy) ? sx : (rm == 3'b010), 31'd0};
      end
      // bring both to the smaller exponent, exact integers
      if (xz) begin
         emin = ey;
      end else if (yz) begin
         emin = ex;
      end else begin
         emin = (ex < ey) ? ex : ey;
      end
      if (!xz) begin
         mx = mx << (ex - emin);
      end
      if (!yz) begin
         my = my << (ey - emin);
      end
      if (sx == sy) begin
         mag = mx + my;
         s   = sx;
      end else if (mx >= my) begin
         mag = mx - my;
         s   = sx;
      end else begin
         mag = my - mx;
         s   = sy;
      end
      // exact zero sum, sign from rounding mode
      if (mag == '0) begin
         return {5'd0, rm == 3'b010, 31'd0};
      end
      return round_to_single(s, mag, emin - 150, rm);
   endfunction

   task automatic compare_outputs(input logic [36:0] e, input logic [31:0] x,
                                  input logic [31:0] y, input logic [9:0] op);
      checks++;
      assert (result === e[31:0]) else begin
         $display("[ERROR] result: got %h, expected %h (a %h, b %h, funct7 %h, frm %h)",
                  result, e[31:0], x, y, op[6:0], op[9:7]);
         errors++;
      end
      assert (flags === e[36:32]) else begin
         $display("[ERROR] flags: got %h, expected %h (a %h, b %h, funct7 %h, frm %h)",
                  flags, e[36:32], x, y, op[6:0], op[9:7]);
         errors++;
      end
   endtask

   // entries whose two-edge latency ends on this falling edge
   task automatic check_due();
      while ((q_due.size() > 0) && (q_due[0] == cyc)) begin
         compare_outputs(q_exp[0], q_a[0], q_b[0], q_op[0]);
         void'(q_due.pop_front());
         void'(q_a.pop_front());
         void'(q_b.pop_front());
         void'(q_op.pop_front());
         void'(q_exp.pop_front());
      end
   endtask

   task automatic issue(input logic [31:0] x, input logic [31:0] y,
                        input logic [6:0] f7, input logic [2:0] rm);
      @(negedge clk);
      cyc++;
      check_due();
      a      = x;
      b      = y;
      funct7 = f7;
      frm    = rm;
      q_due.push_back(cyc + 2);
      q_a.push_back(x);
      q_b.push_back(y);
      q_op.push_back({rm, f7});
      q_exp.push_back(fp_model(x, y, f7, rm));
   endtask

   // idle cycles until every issued operation is checked
   task automatic drain();
      int n;
      n = 0;
      while ((q_due.size() > 0) && (n < 20)) begin
         @(negedge clk);
         cyc++;
         check_due();
         funct7 = F_NOP;
         n++;
      end
      if (q_due.size() > 0) begin
         $display("timeout: %0d results still pending after 20 idle cycles", q_due.size());
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while ((nrst !== 1'b1) && (n < 10)) begin
         @(posedge clk);
         n++;
      end
      if (nrst !== 1'b1) begin
         $display("timeout: reset still asserted after 10 cycles");
         timed_out = 1'b1;
      end
   endtask

   task automatic end_test(input int num, input string name);
      drain();
      tests_run++;
      if (errors != test_err0) begin
         tests_failed++;
      end
      $display("test %0d %s: %s (%0d errors)", num, name,
               (errors == test_err0) ? "ok" : "failed", errors - test_err0);
      test_err0 = errors;
   endtask

   initial begin
      logic [31:0] x;
      logic [31:0] y;
      logic [6:0]  f7;
      int          ea;
      int          eb;
      seed         = 32'h1482;
      a            = '0;
      b            = '0;
      funct7       = F_NOP;
      frm          = 3'd0;
      cyc          = 0;
      checks       = 0;
      errors       = 0;
      test_err0    = 0;
      tests_run    = 0;
      tests_failed = 0;
      timed_out    = 1'b0;

      // reset state with an unknown opcode held
      wait_reset_release();
      @(negedge clk);
      compare_outputs('0, a, b, {frm, funct7});
      for (int k = 0; k < 4; k++) begin
         issue(rand_fp(127), rand_fp(127), F_NOP, 3'd0);
      end
      end_test(1, "reset state");

      // add and sub, exponents at most 30 apart
      for (int k = 0; k < 300; k++) begin
         ea = 1 + int'(rnd(254));
         eb = ea + int'(rnd(61)) - 30;
         if (eb < 1) begin
            eb = 1;
         end
         if (eb > 254) begin
            eb = 254;
         end
         f7 = (rnd(2) == 32'd0) ? F_ADD : F_SUB;
         issue(rand_fp(ea), rand_fp(eb), f7, 3'(rnd(5)));
      end
      end_test(2, "random add/sub");

      // mul near bias, near overflow and near underflow
      for (int k = 0; k < 300; k++) begin
         case (rnd(3))
            32'd0: begin
               ea = 100 + int'(rnd(55));
               eb = 100 + int'(rnd(55));
            end
            32'd1: begin
               ea = 160 + int'(rnd(95));
               eb = 160 + int'(rnd(95));
            end
            default: begin
               ea = 1 + int'(rnd(70));
               eb = 1 + int'(rnd(70));
            end
         endcase
         issue(rand_fp(ea), rand_fp(eb), F_MUL, 3'(rnd(5)));
      end
      end_test(3, "random mul");

      // every pair of special operands in all three operations
      for (int op = 0; op < 3; op++) begin
         for (int i = 0; i < 10; i++) begin
            for (int j = 0; j < 10; j++) begin
               issue(specials[i], specials[j], valid_ops[op], 3'((i + j) % 5));
            end
         end
      end
      end_test(4, "special values");

      // exact and near cancellation
      for (int k = 0; k < 50; k++) begin
         x = rand_fp(1 + int'(rnd(254)));
         issue(x, x, F_SUB, 3'(k % 5));
         issue(x, x ^ 32'h80000000, F_ADD, 3'(k % 5));
         // one fraction bit apart, long normalization shift
         y = x ^ (32'h1 << rnd(23));
         issue(x, y, F_SUB, 3'(rnd(5)));
      end
      end_test(5, "cancellation");

      // unknown codes between valid operations
      for (int k = 0; k < 60; k++) begin
         f7 = 7'(rnd(128));
         if ((f7 == F_ADD) || (f7 == F_SUB) || (f7 == F_MUL)) begin
            f7 = f7 ^ 7'h01;
         end
         issue(rand_fp(100 + int'(rnd(50))), rand_fp(100 + int'(rnd(50))), f7, 3'(rnd(5)));
         issue(rand_fp(100 + int'(rnd(50))), rand_fp(100 + int'(rnd(50))),
               valid_ops[rnd(3)], 3'(rnd(5)));
      end
      end_test(6, "unknown opcodes");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if ((errors == 0) && !timed_out) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
design/fpu_pkg.sv
design/fpu_stage_if.sv
design/fpu_decode.sv
design/fpu_execute.sv
design/fpu_result.sv
design/fpu_top.sv
dv/fpu_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fpu_tb -f verilog.f -Mdir obj_dir
	./obj_dir/Vfpu_tb | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
